// File: Bender.yml
package:
  name: pic_mesh

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pic_pkg.sv
      - source/emesh_rx.sv
      - source/pic_regs.sv
      - source/pic_core.sv
      - source/emesh_tx.sv
      - source/pic_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_pic_top.sv

// File: compile.f
+incdir+source
source/pic_pkg.sv
source/emesh_rx.sv
source/pic_regs.sv
source/pic_core.sv
source/emesh_tx.sv
source/pic_top.sv
test/tb_pic_top.sv

// File: source/emesh_rx.sv
// Ingress buffer; trusts the sender's credit count, an access while full would overwrite the head
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module emesh_rx (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   access_in,   // One packet, costs the sender a credit
   input  pic_pkg::emesh_packet_t packet_in,
   output logic                   credit_out,  // One pulse per freed slot
   output logic                   rx_valid,    // Head packet present
   output pic_pkg::emesh_packet_t rx_pkt,
   input  logic                   rx_pop       // Head consumed this cycle
);

   localparam int PTR_W = $clog2(`PIC_RX_DEPTH);
   localparam int CNT_W = PTR_W + 1;
   localparam logic [PTR_W-1:0] LAST = PTR_W'(`PIC_RX_DEPTH - 1);

   // ################################################
   // Storage and pointers
   // ################################################

   pic_pkg::emesh_packet_t mem [`PIC_RX_DEPTH];

   logic [PTR_W-1:0] wr_ptr;  // Next free slot
   logic [PTR_W-1:0] rd_ptr;  // Head slot
   logic [CNT_W-1:0] count;   // Occupancy 0..DEPTH
   logic             pop;

   assign pop = rx_pop & rx_valid;  // Ignore pops on an empty buffer

   // Slot write, no reset on payload
   always_ff @(posedge clk) begin
      if (access_in)
         mem[wr_ptr] <= packet_in;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_out <= 1'b0;
      end else begin
         // Wrap by compare so odd depths work too
         if (access_in)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;

         count      <= count + CNT_W'(access_in) - CNT_W'(pop);  // Push and pop cancel
         credit_out <= pop;  // Credit goes back one cycle after the pop
      end
   end

   // ################################################
   // Head offered to the register block
   // ################################################

   // A packet written at edge N shows up here after N
   assign rx_valid = (count != '0);
   assign rx_pkt   = mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/emesh_tx.sv
// Egress stage; a credit is spent at load, and at most one response every other cycle
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module emesh_tx (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   tx_load,    // Only while tx_ready
   input  pic_pkg::emesh_packet_t tx_pkt,
   output logic                   tx_ready,
   output logic                   access_out, // One cycle per response
   output pic_pkg::emesh_packet_t packet_out,
   input  logic                   credit_in   // One credit back per pulse
);

   localparam int CW = $clog2(`PIC_TX_CREDITS + 1);
   localparam logic [CW-1:0] MAX_CREDITS = CW'(`PIC_TX_CREDITS);

   logic [CW-1:0] credits;  // Credits not yet spent

   // ################################################
   // Credit counter
   // ################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= MAX_CREDITS;
      end else begin
         case ({tx_load, credit_in})
            2'b10: credits <= credits - 1'b1;
            2'b01: begin
               if (credits != MAX_CREDITS)  // Saturate on stray returns
                  credits <= credits + 1'b1;
            end
            default: ;                      // Both or neither
         endcase
      end
   end

   // No load while a response is on the wire
   assign tx_ready = (credits != '0) & ~access_out;

   // ################################################
   // Output register
   // ################################################

   always_ff @(posedge clk) begin
      if (!rst_n)
         access_out <= 1'b0;
      else
         access_out <= tx_load;
   end

   always_ff @(posedge clk) begin
      if (tx_load)
         packet_out <= tx_pkt;  // Held until the next load
   end

endmodule

`default_nettype wire

// File: source/pic_consts.svh
// Shared sizes; PIC_RX_DEPTH must be at least 2 and PIC_IW at most 30 for the register map
`ifndef PIC_CONSTS_SVH
`define PIC_CONSTS_SVH

// ################################################
// Datapath sizes
// ################################################

// Address and data width of mesh packets
`define PIC_AW 32

// Interrupt lines, index 0 ranks highest
`define PIC_IW 10

// ################################################
// Flow control
// ################################################

// Ingress slots, equal to the sender's starting credits
`define PIC_RX_DEPTH 4

// Egress credits held after reset
`define PIC_TX_CREDITS 4

// ################################################
// Reset values
// ################################################

`define PIC_IVT_RESET 32'h0000_0100

`endif

// File: source/pic_core.sv
// Interrupt core; one request in flight, the vector is frozen while irq is high
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module pic_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pic_pkg::pic_cmd_t    cmd,
   output pic_pkg::pic_status_t status,
   input  logic [`PIC_IW-1:0]   ext_irq,   // Level or pulse, sampled every edge
   input  logic [`PIC_AW-1:0]   pc_next,   // Return address captured on ack
   input  logic                 irq_en,    // Global enable from the sequencer
   input  logic                 irq_ack,
   input  logic                 rti,       // Return from interrupt
   output logic                 irq,
   output logic [`PIC_AW-1:0]   irq_addr
);

   localparam int AW    = `PIC_AW;
   localparam int IW    = `PIC_IW;
   localparam int IDX_W = $clog2(IW);

   pic_pkg::pic_state_e state;
   pic_pkg::pic_state_e state_nxt;

   logic [IW-1:0]    ilat;
   logic [IW-1:0]    ilat_nxt;
   logic [IW-1:0]    ipend;
   logic [IW-1:0]    ipend_nxt;
   logic [AW-1:0]    iret;
   logic [IW-1:0]    pend_low;  // Lowest pending bit, one-hot
   logic [IW-1:0]    allowed;   // Lines that outrank every pending one
   logic [IW-1:0]    cand;      // Eligible lines
   logic [IDX_W-1:0] sel_idx;   // Winner this cycle
   logic             sel_vld;
   logic [IDX_W-1:0] req_idx;   // Line being offered
   logic             req_ok;    // Offered line still eligible
   logic             ack_fire;

   // ################################################
   // Priority selection
   // ################################################

   assign pend_low = ipend & (~ipend + 1'b1);
   assign allowed  = (ipend == '0) ? '1 : pend_low - 1'b1;  // Strictly below lowest pending
   assign cand     = ilat & ~cmd.imask & allowed;

   // Lowest index wins, last hit in the loop
   always_comb begin
      sel_idx = '0;
      for (int i = IW - 1; i >= 0; i--) begin
         if (cand[i])
            sel_idx = IDX_W'(i);
      end
   end

   assign sel_vld  = irq_en & (cand != '0);
   assign req_ok   = irq_en & cand[req_idx];
   assign ack_fire = irq_ack & (state == pic_pkg::REQUEST);

   // ################################################
   // Next state of latch, pending and FSM
   // ################################################

   always_comb begin
      ilat_nxt  = (ilat | ext_irq | cmd.ilat_set) & ~cmd.ilat_clr;  // Clear beats set
      ipend_nxt = ipend;
      state_nxt = state;
      if (rti)
         ipend_nxt = ipend & ~pend_low;  // Innermost level done
      case (state)
         pic_pkg::IDLE: begin
            if (sel_vld)
               state_nxt = pic_pkg::REQUEST;
         end
         pic_pkg::REQUEST: begin
            // Ack wins, the processor already took the vector
            if (ack_fire) begin
               ilat_nxt[req_idx]  = 1'b0;
               ipend_nxt[req_idx] = 1'b1;   // Ranks below all pending, no clash with rti
               state_nxt          = pic_pkg::IDLE;
            end else if (!req_ok) begin
               state_nxt = pic_pkg::IDLE;   // Masked, cleared or disabled
            end
         end
         default: state_nxt = pic_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= pic_pkg::IDLE;
         ilat  <= '0;
         ipend <= '0;
         iret  <= '0;
      end else begin
         state <= state_nxt;
         ilat  <= ilat_nxt;
         ipend <= ipend_nxt;
         if (ack_fire)
            iret <= pc_next;
      end
   end

   // Vector frozen on entry to REQUEST
   always_ff @(posedge clk) begin
      if (state == pic_pkg::IDLE && sel_vld) begin
         req_idx  <= sel_idx;
         irq_addr <= cmd.ivt_base + (AW'(sel_idx) << 2);  // 4 bytes per entry
      end
   end

   assign irq = (state == pic_pkg::REQUEST);

   assign status.ilat  = ilat;
   assign status.ipend = ipend;
   assign status.iret  = iret;

endmodule

`default_nettype wire

// File: source/pic_pkg.sv
// Types for the mesh interrupt controller; the field order of emesh_packet_t is the wire format
`default_nettype none

`include "pic_consts.svh"

package pic_pkg;

   // ################################################
   // Mesh packet, 104 bits, write bit on top
   // ################################################
   typedef struct packed {
      logic                write;     // 1 = write, responses always 1
      logic [1:0]          datamode;  // Copied into responses
      logic [4:0]          ctrlmode;  // Copied into responses
      logic [`PIC_AW-1:0]  dstaddr;   // Bits 7:2 select the register
      logic [`PIC_AW-1:0]  srcaddr;   // Return address for reads
      logic [`PIC_AW-1:0]  data;
   } emesh_packet_t;

   // Register opcode, dstaddr[7:2]
   typedef enum logic [5:0] {
      ILAT     = 6'd0,  // Read only
      ILAT_SET = 6'd1,  // Write ones to set
      ILAT_CLR = 6'd2,  // Write ones to clear
      IMASK    = 6'd3,  // 1 blocks the line
      IPEND    = 6'd4,  // Read only
      IRET     = 6'd5,  // Read only
      IVT      = 6'd6   // Vector table base
   } pic_reg_e;

   // Register block to core
   typedef struct packed {
      logic [`PIC_IW-1:0] ilat_set;  // One-cycle strobe mask
      logic [`PIC_IW-1:0] ilat_clr;  // One-cycle strobe mask, wins over set
      logic [`PIC_IW-1:0] imask;
      logic [`PIC_AW-1:0] ivt_base;
   } pic_cmd_t;

   // Core back to register block
   typedef struct packed {
      logic [`PIC_IW-1:0] ilat;
      logic [`PIC_IW-1:0] ipend;
      logic [`PIC_AW-1:0] iret;
   } pic_status_t;

   // Core FSM
   typedef enum logic {
      IDLE,
      REQUEST
   } pic_state_e;

endpackage

`default_nettype wire

// File: source/pic_regs.sv
// Register decode; only dstaddr[7:2] is decoded so the map aliases through the upper address bits
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module pic_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_valid,
   input  pic_pkg::emesh_packet_t rx_pkt,
   output logic                   rx_pop,
   input  logic                   tx_ready,  // Egress can take a response now
   output logic                   tx_load,
   output pic_pkg::emesh_packet_t tx_pkt,
   output pic_pkg::pic_cmd_t      cmd,
   input  pic_pkg::pic_status_t   status
);

   localparam int AW = `PIC_AW;
   localparam int IW = `PIC_IW;

   pic_pkg::pic_reg_e op;        // Opcode of the head packet
   logic              wr_fire;   // Write retired this cycle
   logic              rd_fire;   // Read retired this cycle
   logic [IW-1:0]     imask;
   logic [AW-1:0]     ivt_base;
   logic [AW-1:0]     rd_data;

   // ################################################
   // Decode and pop
   // ################################################

   // Unknown codes fall through to the defaults below
   assign op = pic_pkg::pic_reg_e'(rx_pkt.dstaddr[7:2]);

   // Writes leave at once, reads wait for egress room
   assign rx_pop  = rx_valid & (rx_pkt.write | tx_ready);
   assign wr_fire = rx_pop & rx_pkt.write;
   assign rd_fire = rx_pop & ~rx_pkt.write;

   // Local registers, new value visible the cycle after the pop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         imask    <= '0;               // Everything unmasked
         ivt_base <= `PIC_IVT_RESET;
      end else if (wr_fire) begin
         case (op)
            pic_pkg::IMASK: imask    <= rx_pkt.data[IW-1:0];
            pic_pkg::IVT:   ivt_base <= rx_pkt.data;
            default:        ;          // Latch strobes go to the core, rest ignored
         endcase
      end
   end

   // Command to core
   always_comb begin
      cmd.ilat_set = '0;
      cmd.ilat_clr = '0;
      cmd.imask    = imask;
      cmd.ivt_base = ivt_base;
      // Strobes live for the pop cycle only
      if (wr_fire && op == pic_pkg::ILAT_SET)
         cmd.ilat_set = rx_pkt.data[IW-1:0];
      if (wr_fire && op == pic_pkg::ILAT_CLR)
         cmd.ilat_clr = rx_pkt.data[IW-1:0];
   end

   // ################################################
   // Read path
   // ################################################

   always_comb begin
      case (op)
         pic_pkg::ILAT:  rd_data = AW'(status.ilat);   // Zero extended
         pic_pkg::IMASK: rd_data = AW'(imask);
         pic_pkg::IPEND: rd_data = AW'(status.ipend);
         pic_pkg::IRET:  rd_data = status.iret;
         pic_pkg::IVT:   rd_data = ivt_base;
         default:        rd_data = '0;                 // Strobe regs and holes
      endcase
   end

   // Response swaps the addresses and keeps the modes
   always_comb begin
      tx_pkt.write    = 1'b1;
      tx_pkt.datamode = rx_pkt.datamode;
      tx_pkt.ctrlmode = rx_pkt.ctrlmode;
      tx_pkt.dstaddr  = rx_pkt.srcaddr;  // Back to the requester
      tx_pkt.srcaddr  = rx_pkt.dstaddr;
      tx_pkt.data     = rd_data;
   end

   assign tx_load = rd_fire;  // Egress registers it at the pop edge

endmodule

`default_nettype wire

// File: source/pic_top.sv
// Controller top; one clock domain, credit flow control on both packet ports
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module pic_top (
   input  logic                   clk,
   input  logic                   rst_n,
   // Register requests in
   input  logic                   access_in,
   input  pic_pkg::emesh_packet_t packet_in,
   output logic                   credit_out,
   // Read responses out
   output logic                   access_out,
   output pic_pkg::emesh_packet_t packet_out,
   input  logic                   credit_in,
   // Processor side
   input  logic [`PIC_IW-1:0]     ext_irq,
   input  logic [`PIC_AW-1:0]     pc_next,
   input  logic                   irq_en,
   input  logic                   irq_ack,
   input  logic                   rti,
   output logic                   irq,
   output logic [`PIC_AW-1:0]     irq_addr
);

   logic                   rx_valid;
   pic_pkg::emesh_packet_t rx_pkt;
   logic                   rx_pop;
   logic                   tx_ready;
   logic                   tx_load;
   pic_pkg::emesh_packet_t tx_pkt;
   pic_pkg::pic_cmd_t      cmd;     // Regs to core
   pic_pkg::pic_status_t   status;  // Core to regs

   // Ingress buffer
   emesh_rx rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .credit_out (credit_out),
      .rx_valid   (rx_valid),
      .rx_pkt     (rx_pkt),
      .rx_pop     (rx_pop)
   );

   pic_regs regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .rx_valid (rx_valid),
      .rx_pkt   (rx_pkt),
      .rx_pop   (rx_pop),
      .tx_ready (tx_ready),
      .tx_load  (tx_load),
      .tx_pkt   (tx_pkt),
      .cmd      (cmd),
      .status   (status)
   );

   pic_core core (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd      (cmd),
      .status   (status),
      .ext_irq  (ext_irq),
      .pc_next  (pc_next),
      .irq_en   (irq_en),
      .irq_ack  (irq_ack),
      .rti      (rti),
      .irq      (irq),
      .irq_addr (irq_addr)
   );

   // Egress register
   emesh_tx tx (
      .clk        (clk),
      .rst_n      (rst_n),
      .tx_load    (tx_load),
      .tx_pkt     (tx_pkt),
      .tx_ready   (tx_ready),
      .access_out (access_out),
      .packet_out (packet_out),
      .credit_in  (credit_in)
   );

endmodule

`default_nettype wire

// File: test/tb_pic_top.sv
// Testbench for pic_top; needs a free-running receiver credit loop except where the test holds it
`timescale 1ns/1ps
`default_nettype none

`include "pic_consts.svh"

module tb_pic_top;

   localparam int          IW        = `PIC_IW;
   localparam int          TIMEOUT   = 200;              // Cycles allowed per wait loop
   localparam logic [31:0] NODE_BASE = 32'h8000_0000;    // Upper address bits of this node
   localparam logic [1:0]  DMODE     = 2'b10;
   localparam logic [4:0]  CMODE     = 5'h15;
   localparam logic [IW-1:0] ALL     = '1;

   logic                   clk;
   logic                   rst_n;
   logic                   access_in;
   pic_pkg::emesh_packet_t packet_in;
   logic                   credit_out;
   logic                   access_out;
   pic_pkg::emesh_packet_t packet_out;
   logic                   credit_in;
   logic [IW-1:0]          ext_irq;
   logic [31:0]            pc_next;
   logic                   irq_en;
   logic                   irq_ack;
   logic                   rti;
   logic                   irq;
   logic [31:0]            irq_addr;

   int                     errors;
   int                     checks;
   int                     sent;          // Packets handed to the DUT
   int                     credit_ret;    // credit_out pulses seen
   int                     give_credits;  // Manual credit_in pulses still owed
   bit                     auto_credit;   // Receiver returns a credit per response
   logic [31:0]            seed;
   pic_pkg::emesh_packet_t rsp_q[$];      // Responses in arrival order

   // Register model
   logic [IW-1:0]          m_imask;
   logic [31:0]            m_ivt;
   logic [IW-1:0]          m_lat;
   logic [31:0]            m_iret;

   pic_top uut (
      .clk(clk), .rst_n(rst_n),
      .access_in(access_in), .packet_in(packet_in), .credit_out(credit_out),
      .access_out(access_out), .packet_out(packet_out), .credit_in(credit_in),
      .ext_irq(ext_irq), .pc_next(pc_next), .irq_en(irq_en), .irq_ack(irq_ack),
      .rti(rti), .irq(irq), .irq_addr(irq_addr)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // ################################################
   // Models and helpers
   // ################################################

   // Receiver side and response capture sampled mid-cycle
   always @(negedge clk) begin
      if (access_out)
         rsp_q.push_back(packet_out);
      if (credit_out)
         credit_ret++;
      if (auto_credit && access_out) begin
         credit_in = 1'b1;
      end else if (give_credits > 0) begin
         credit_in = 1'b1;
         give_credits--;
      end else begin
         credit_in = 1'b0;
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
      return seed;
   endfunction

   // Index 0 ranks highest
   function automatic int lowest_set(input logic [IW-1:0] v);
      int idx;
      idx = -1;
      for (int i = IW - 1; i >= 0; i--)
         if (v[i])
            idx = i;
      return idx;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [5:0] op);
      return NODE_BASE | {24'd0, op, 2'b00};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic abort_run(input string what);
      errors++;
      $display("Timeout: %s", what);
      $display("checks=%0d errors=%0d", checks, errors);
      $display("Simulation failed");
      $finish;
   endtask

   // Called and returns on a falling edge
   task automatic send_pkt(input logic wr, input logic [5:0] op, input logic [31:0] data,
                           input logic [31:0] src);
      int t;
      t = 0;
      while (sent - credit_ret >= `PIC_RX_DEPTH && t < TIMEOUT) begin  // No credit in hand
         @(negedge clk);
         t++;
      end
      if (t >= TIMEOUT)
         abort_run("sender never got a credit back");
      packet_in.write    = wr;
      packet_in.datamode = DMODE;
      packet_in.ctrlmode = CMODE;
      packet_in.dstaddr  = reg_addr(op);
      packet_in.srcaddr  = src;
      packet_in.data     = data;
      access_in          = 1'b1;
      sent++;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic wait_rsp(input int n);
      int t;
      t = 0;
      while (rsp_q.size() < n && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (rsp_q.size() < n)
         abort_run("read response did not arrive");
   endtask

   task automatic wait_irq(input logic level);
      int t;
      t = 0;
      while (irq !== level && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (irq !== level)
         abort_run("irq never reached the expected level");
   endtask

   task automatic wait_credits();
      int t;
      t = 0;
      while (credit_ret < sent && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (credit_ret < sent)
         abort_run("ingress credits were not all returned");
   endtask

   // Oldest response against expectations
   task automatic check_rsp(input logic [31:0] exp, input logic [31:0] src,
                            input logic [5:0] op, input string name);
      pic_pkg::emesh_packet_t p;
      p = rsp_q.pop_front();
      check_val({"packet_out.data ", name}, p.data, exp);
      check_val("packet_out.dstaddr", p.dstaddr, src);   // Back to the requester
      check_val("packet_out.srcaddr", p.srcaddr, reg_addr(op));
      check_val("packet_out.write", 32'(p.write), 32'd1);
      check_val("packet_out.ctrlmode", 32'(p.ctrlmode), 32'(CMODE));
      check_val("packet_out.datamode", 32'(p.datamode), 32'(DMODE));
   endtask

   task automatic write_reg(input logic [5:0] op, input logic [31:0] data);
      send_pkt(1'b1, op, data, next_rand());
   endtask

   task automatic read_reg(input logic [5:0] op, input logic [31:0] exp, input string name);
      logic [31:0] src;
      src = next_rand();
      send_pkt(1'b0, op, 32'd0, src);
      wait_rsp(1);
      check_rsp(exp, src, op, name);
   endtask

   // ################################################
   // Test sequence
   // ################################################

   initial begin
      logic [31:0] v;
      logic [31:0] pc;
      logic [31:0] srcs[6];
      logic [5:0]  ops[6];
      logic [31:0] exps[6];
      int          hi;
      int          lo;
      rst_n        = 1'b0;
      access_in    = 1'b0;
      packet_in    = '0;
      credit_in    = 1'b0;
      ext_irq      = '0;
      pc_next      = '0;
      irq_en       = 1'b0;
      irq_ack      = 1'b0;
      rti          = 1'b0;
      errors       = 0;
      checks       = 0;
      sent         = 0;
      credit_ret   = 0;
      give_credits = 0;
      auto_credit  = 1'b1;
      seed         = 32'hdf617119;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // 1 Reset values
      check_val("irq", 32'(irq), 32'd0);
      check_val("access_out", 32'(access_out), 32'd0);
      check_val("credit_out", 32'(credit_out), 32'd0);
      m_imask = '0;
      m_ivt   = `PIC_IVT_RESET;
      m_lat   = '0;
      m_iret  = '0;
      read_reg(pic_pkg::IMASK, 32'd0, "IMASK");
      read_reg(pic_pkg::ILAT, 32'd0, "ILAT");
      read_reg(pic_pkg::IPEND, 32'd0, "IPEND");
      read_reg(pic_pkg::IVT, m_ivt, "IVT");

      // 2 Readback with the upper data bits of IMASK dropped
      for (int i = 0; i < 4; i++) begin
         v = next_rand();
         m_imask = v[IW-1:0];
         write_reg(pic_pkg::IMASK, v);
         read_reg(pic_pkg::IMASK, 32'(m_imask), "IMASK");
         m_ivt = next_rand();
         write_reg(pic_pkg::IVT, m_ivt);
         read_reg(pic_pkg::IVT, m_ivt, "IVT");
      end
      read_reg(6'd20, 32'd0, "unknown");
      m_imask = '0;
      write_reg(pic_pkg::IMASK, 32'd0);
      read_reg(pic_pkg::IMASK, 32'd0, "IMASK");

      // 3 Latching with irq_en low so the vector sees every bit
      for (int i = 0; i < 3; i++) begin
         v = next_rand();
         if (v[IW-1:0] == '0)
            v = 32'd1;
         ext_irq = v[IW-1:0];
         m_lat   = m_lat | v[IW-1:0];
         @(negedge clk);
         ext_irq = '0;
      end
      read_reg(pic_pkg::ILAT, 32'(m_lat), "ILAT");
      irq_en = 1'b1;
      wait_irq(1'b1);
      check_val("irq_addr", irq_addr, m_ivt + 32'(4 * lowest_set(m_lat & ~m_imask)));
      write_reg(pic_pkg::IMASK, 32'(ALL));  // Everything blocked
      m_imask = ALL;
      wait_irq(1'b0);
      v = next_rand();
      v[lowest_set(m_lat)] = 1'b1;  // At least one latched line goes
      write_reg(pic_pkg::ILAT_CLR, v);
      m_lat = m_lat & ~v[IW-1:0];
      read_reg(pic_pkg::ILAT, 32'(m_lat), "ILAT");
      irq_en = 1'b0;

      // 4 Nesting where hi outranks lo
      write_reg(pic_pkg::ILAT_CLR, 32'(ALL));
      write_reg(pic_pkg::IMASK, 32'd0);
      m_imask = '0;
      m_lat   = '0;
      read_reg(pic_pkg::ILAT, 32'd0, "ILAT");  // Also drains the writes
      hi = int'(next_rand() % 32'(IW - 1));
      lo = hi + 1 + int'(next_rand() % 32'(IW - 1 - hi));
      ext_irq = (IW'(1) << hi) | (IW'(1) << lo);
      @(negedge clk);
      ext_irq = '0;
      irq_en  = 1'b1;
      wait_irq(1'b1);
      check_val("irq_addr", irq_addr, m_ivt + 32'(4 * hi));
      pc      = next_rand();
      pc_next = pc;
      irq_ack = 1'b1;
      @(negedge clk);
      irq_ack = 1'b0;
      m_iret  = pc;
      m_lat   = IW'(1) << lo;
      repeat (4) begin
         @(negedge clk);
         check_val("irq", 32'(irq), 32'd0);  // lo blocked by pending hi
      end
      read_reg(pic_pkg::IRET, m_iret, "IRET");
      read_reg(pic_pkg::IPEND, 32'(IW'(1) << hi), "IPEND");
      read_reg(pic_pkg::ILAT, 32'(m_lat), "ILAT");
      rti = 1'b1;
      @(negedge clk);
      rti = 1'b0;
      wait_irq(1'b1);
      check_val("irq_addr", irq_addr, m_ivt + 32'(4 * lo));
      read_reg(pic_pkg::IPEND, 32'd0, "IPEND");
      irq_en = 1'b0;
      wait_irq(1'b0);

      // 5 Egress back-pressure
      auto_credit = 1'b0;
      repeat (3) @(negedge clk);  // Last auto credit lands
      ops  = '{pic_pkg::IMASK, pic_pkg::IVT, 6'd20, pic_pkg::IPEND, pic_pkg::ILAT, pic_pkg::IRET};
      exps = '{32'(m_imask), m_ivt, 32'd0, 32'd0, 32'(m_lat), m_iret};
      for (int i = 0; i < 6; i++) begin
         srcs[i] = next_rand();
         send_pkt(1'b0, ops[i], 32'd0, srcs[i]);
      end
      wait_rsp(`PIC_TX_CREDITS);
      repeat (8) @(negedge clk);
      check_val("response count", 32'(rsp_q.size()), 32'(`PIC_TX_CREDITS));
      give_credits = 6 - `PIC_TX_CREDITS;
      wait_rsp(6);
      for (int i = 0; i < 6; i++)
         check_rsp(exps[i], srcs[i], ops[i], "queued read");
      wait_credits();
      check_val("credit_out pulses", 32'(credit_ret), 32'(sent));

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
